//--- Bender.yml
package:
  name: vmem_top

sources:
  # packages first, then the interface and the design blocks
  - files:
      - mem_bus_pkg.sv
      - vec_unit_pkg.sv
      - data_port_if.sv
      - rst_sync.sv
      - data_arbiter.sv
      - req_tracker.sv
      - vmem_top.sv

  # simulation only
  - target: test
    files:
      - tb_vmem_top.sv

//--- compile.f
mem_bus_pkg.sv
vec_unit_pkg.sv
data_port_if.sv
rst_sync.sv
data_arbiter.sv
req_tracker.sv
vmem_top.sv
tb_vmem_top.sv

//--- data_arbiter.sv
// data arbiter between the scalar and the vector load/store ports
// applies vector priority and hazard holds, aligns scalar lanes, routes responses

`timescale 1ns/1ps

module data_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    data_port_if.arbiter           sport,
    data_port_if.arbiter           vport,
    input  vec_unit_pkg::vid_t     vreq_id_i,
    output vec_unit_pkg::vid_t     vres_id_o,
    input  logic                   vec_pending_load_i,
    input  logic                   vec_pending_store_i,
    input  logic                   full_i,
    input  logic                   rd_done_i,
    input  logic                   wr_done_i,
    output logic                   mem_req_o,
    output mem_bus_pkg::addr_t     mem_addr_o,
    output logic                   mem_we_o,
    output mem_bus_pkg::mem_be_t   mem_be_o,
    output mem_bus_pkg::mem_data_t mem_wdata_o,
    input  logic                   mem_err_i,
    input  mem_bus_pkg::mem_data_t mem_rdata_i
);
    import mem_bus_pkg::*;
    import vec_unit_pkg::*;

    req_src_e              owner_q;
    logic [LANE_IDX_W-1:0] lane_q;
    vid_t                  vid_q;
    logic [LANE_IDX_W-1:0] s_lane;
    mem_op_e               s_op;
    mem_op_e               bus_op;
    logic                  resp;
    logic                  s_hold;
    logic                  v_hold;
    logic                  s_gnt;
    logic                  v_gnt;
    logic                  s_own;
    logic                  v_own;

    assign s_lane = sport.addr[LANE_IDX_W+1:2];
    assign s_op   = sport.we ? OP_WRITE : OP_READ;
    assign resp   = rd_done_i | wr_done_i;
    assign s_own  = owner_q == SRC_SCALAR;
    assign v_own  = owner_q == SRC_VECTOR;

    ////////////////////
    // grants

    // scalar waits behind vector traffic and any vector hazard
    assign s_hold = vport.req | vec_pending_store_i
                  | (vec_pending_load_i & (s_op == OP_WRITE)) | v_own;
    // vector only waits for a scalar response not yet returned
    assign v_hold = s_own & ~resp;

    assign v_gnt     = vport.req & ~v_hold & ~full_i;
    assign s_gnt     = sport.req & ~s_hold & ~full_i;
    assign vport.gnt = v_gnt;
    assign sport.gnt = s_gnt;
    assign mem_req_o = v_gnt | s_gnt;

    // bus fields follow the vector port whenever it requests
    always_comb begin
        bus_op      = s_op;
        mem_addr_o  = sport.addr;
        mem_be_o    = mem_be_t'(sport.be) << (4 * s_lane);
        mem_wdata_o = {LANE_CNT{sport.wdata}};
        if (vport.req) begin
            bus_op      = vport.we ? OP_WRITE : OP_READ;
            mem_addr_o  = vport.addr;
            mem_be_o    = vport.be;
            mem_wdata_o = vport.wdata;
        end
    end

    assign mem_we_o = bus_op == OP_WRITE;

    ////////////////////
    // owner tracking

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= SRC_NONE;
        end else if (v_gnt) begin
            owner_q <= SRC_VECTOR;
        end else if (s_gnt) begin
            owner_q <= SRC_SCALAR;
        end else if (resp) begin
            owner_q <= SRC_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (v_gnt) begin
            vid_q <= vreq_id_i;
        end
        if (s_gnt) begin
            lane_q <= s_lane;
        end
    end

    ////////////////////
    // response routing

    assign sport.rvalid = resp & s_own;
    assign vport.rvalid = resp & v_own;
    assign sport.err    = resp & s_own & mem_err_i;
    assign vport.err    = resp & v_own & mem_err_i;
    // scalar word comes from the lane it was issued on
    assign sport.rdata  = mem_rdata_i[32*lane_q +: 32];
    assign vport.rdata  = mem_rdata_i;
    assign vres_id_o    = vid_q;

    // scalar lane record stays until its response returns
    owner_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_own && !resp) |-> !s_gnt)
        else $error("data_arbiter: scalar granted again with its response outstanding");

endmodule

//--- data_port_if.sv
// load/store data port
// one requester and the arbiter, data width set per port

`timescale 1ns/1ps

interface data_port_if #(
    parameter int unsigned DATA_W = 32
) ();
    import mem_bus_pkg::*;

    // request side, held stable until gnt
    logic              req;
    addr_t             addr;
    logic              we;
    logic [DATA_W/8-1:0] be;
    logic [DATA_W-1:0] wdata;

    // grant and response side
    logic              gnt;
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;

    modport requester (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, err, rdata
    );

    modport arbiter (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, err, rdata
    );

endinterface

//--- mem_bus_pkg.sv
// memory bus package
// bus geometry, bus word types and the memory operation kinds

package mem_bus_pkg;

    ////////////////////
    // bus geometry

    localparam int unsigned MEM_W      = 64;
    localparam int unsigned MEM_BE_W   = MEM_W / 8;
    // 32-bit lanes per bus word
    localparam int unsigned LANE_CNT   = MEM_W / 32;
    localparam int unsigned LANE_IDX_W = $clog2(LANE_CNT);

    ////////////////////
    // request tracking

    localparam int unsigned TRACK_DEPTH = 32;
    // counter must also hold the value TRACK_DEPTH itself
    localparam int unsigned TRACK_CNT_W = $clog2(TRACK_DEPTH + 1);

    ////////////////////
    // types

    typedef logic [31:0]         addr_t;
    typedef logic [MEM_W-1:0]    mem_data_t;
    typedef logic [MEM_BE_W-1:0] mem_be_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

endpackage

//--- req_tracker.sv
// outstanding request tracker
// remembers the kind of each request in order and splits responses into reads and writes

`timescale 1ns/1ps

module req_tracker (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  mem_bus_pkg::mem_op_e push_op_i,
    input  logic                 mem_rvalid_i,
    output logic                 rd_done_o,
    output logic                 wr_done_o,
    output logic                 full_o
);
    import mem_bus_pkg::*;

    mem_op_e                queue_q [TRACK_DEPTH];
    logic [TRACK_CNT_W-1:0] count_q;
    logic [TRACK_CNT_W-1:0] wr_idx;
    logic                   pop;

    assign pop = mem_rvalid_i;
    // a pop in the same cycle frees the slot below the tail
    assign wr_idx = pop ? count_q - 1'b1 : count_q;

    // shift queue, head at entry 0
    always_ff @(posedge clk_i) begin
        if (pop) begin
            for (int i = 0; i < TRACK_DEPTH - 1; i++) begin
                queue_q[i] <= queue_q[i+1];
            end
        end
        if (push_i) begin
            queue_q[wr_idx[TRACK_CNT_W-2:0]] <= push_op_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (push_i && !pop) begin
            count_q <= count_q + 1'b1;
        end else if (pop && !push_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign full_o    = count_q == TRACK_CNT_W'(TRACK_DEPTH);
    assign rd_done_o = mem_rvalid_i & (queue_q[0] == OP_READ);
    assign wr_done_o = mem_rvalid_i & (queue_q[0] == OP_WRITE);

    // memory answers only what was asked
    no_resp_when_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> count_q != '0)
        else $error("req_tracker: response with no request outstanding");

    // arbiter must stop granting at full
    no_push_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("req_tracker: request granted while tracker full");

endmodule

//--- rst_sync.sv
// reset synchronizer
// asserts asynchronously, releases after a fixed number of clock edges

`timescale 1ns/1ps

module rst_sync (
    input  logic clk_i,
    input  logic rst_ni,
    output logic rst_no
);
    import vec_unit_pkg::*;

    logic [RST_SYNC_STAGES-1:0] sync_q;

    // ones ripple in from stage 0 once rst_ni is released
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // last stage is the released reset
    assign rst_no = sync_q[RST_SYNC_STAGES-1];

endmodule

//--- tb_vmem_top.sv
// testbench for the vector memory top
// random scalar and vector traffic against an in-order memory model

`timescale 1ns/1ps

module tb_vmem_top;
    import mem_bus_pkg::*;
    import vec_unit_pkg::*;

    localparam logic [31:0] LFSR_POLY = 32'hb4bc_d35c;
    localparam int          TMO       = 40;

    typedef struct {
        addr_t addr;
        logic  we;
        logic  vec;
        logic  err;
        vid_t  id;
        int    due;
    } mem_req_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        s_req_i, s_we_i, s_gnt_o, s_rvalid_o, s_err_o;
    addr_t       s_addr_i;
    logic [3:0]  s_be_i;
    logic [31:0] s_wdata_i, s_rdata_o;
    logic        v_req_i, v_we_i, v_gnt_o, v_rvalid_o, v_err_o;
    addr_t       v_addr_i;
    mem_be_t     v_be_i;
    mem_data_t   v_wdata_i, v_rdata_o;
    vid_t        v_id_i, v_res_id_o;
    logic        vec_pending_load_i, vec_pending_store_i, vec_rst_no;
    logic        mem_req_o, mem_we_o, data_read_o;
    addr_t       mem_addr_o;
    mem_be_t     mem_be_o;
    mem_data_t   mem_wdata_o;
    logic        mem_rvalid_i = 1'b0;
    logic        mem_err_i    = 1'b0;
    mem_data_t   mem_rdata_i  = '0;

    // memory model and checker state
    logic [31:0] lfsr        = 32'h8cdb;
    mem_req_t    mq [$];
    mem_data_t   mem_arr [16];
    int          cyc         = 0;
    int          out_cnt     = 0;
    int          v_out       = 0;
    logic        hold_resp   = 1'b0;
    logic        single_mode = 1'b1;
    logic        head_we     = 1'b0;
    logic        head_vec    = 1'b0;
    vid_t        head_id     = '0;
    logic        sread_chk   = 1'b0;
    logic [31:0] exp_sword   = '0;
    int          err_cnt     = 0;
    int          err_mark    = 0;
    int          tests_run   = 0;

    vmem_top dut0 (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_POLY : lfsr >> 1;
        end
        return r;
    endfunction

    task automatic log_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        err_cnt++;
    endtask

    task automatic report_test(input string name);
        $display("test %-14s %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
        tests_run++;
    endtask

    ////////////////////
    // memory model

    // take new requests, retire the answered one
    always @(posedge clk_i or negedge rst_ni) begin
        mem_req_t e;
        int       idx;
        if (!rst_ni) begin
            mq.delete();
            out_cnt = 0;
            v_out   = 0;
        end else begin
            cyc++;
            if (mem_rvalid_i && mq.size() > 0) begin
                if (mq[0].vec) begin
                    v_out--;
                end
                void'(mq.pop_front());
                out_cnt--;
            end
            if (mem_req_o) begin
                // vector wins whenever it requests
                e.addr = mem_addr_o;
                e.we   = v_req_i ? v_we_i : s_we_i;
                e.vec  = v_req_i;
                e.id   = v_id_i;
                e.due  = cyc + 1 + int'(take_bits(2));
                e.err  = take_bits(1) != '0;
                mq.push_back(e);
                out_cnt++;
                if (v_req_i) begin
                    v_out++;
                end
                if (e.we) begin
                    idx = mem_addr_o[6:3];
                    for (int b = 0; b < MEM_BE_W; b++) begin
                        if (mem_be_o[b]) begin
                            mem_arr[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // in-order answers once the head latency has passed
    always @(negedge clk_i) begin
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
        mem_rdata_i  = '0;
        if (rst_ni && !hold_resp && mq.size() > 0 && cyc >= mq[0].due) begin
            mem_rvalid_i = 1'b1;
            mem_err_i    = mq[0].err;
            mem_rdata_i  = mem_arr[mq[0].addr[6:3]];
            head_we      = mq[0].we;
            head_vec     = mq[0].vec;
            head_id      = mq[0].id;
        end
    end

    ////////////////////
    // checks

    reset_quiet_a: assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |->
        !mem_req_o && !data_read_o && !s_gnt_o && !v_gnt_o && !(!rst_ni && vec_rst_no))
        else log_mismatch("bus or grant active during reset");
    vrst_release_a: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !vec_rst_no [*4] ##1 vec_rst_no)
        else log_mismatch("vector reset not released on the fourth edge");

    swrite_lanes_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_gnt_o && s_we_i) |-> mem_we_o && mem_addr_o == s_addr_i
        && mem_wdata_o == {s_wdata_i, s_wdata_i}
        && mem_be_o == (s_addr_i[2] ? {s_be_i, 4'h0} : {4'h0, s_be_i}))
        else log_mismatch("scalar write not lane aligned");
    sread_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_rvalid_o && sread_chk) |-> s_rdata_o == exp_sword)
        else log_mismatch("scalar read returned a wrong word");
    vwrite_bus_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (v_gnt_o && v_we_i) |-> mem_we_o && mem_addr_o == v_addr_i
        && mem_wdata_o == v_wdata_i && mem_be_o == v_be_i)
        else log_mismatch("vector write not passed to the bus");

    prio_bus_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_req_i && v_req_i) |-> !s_gnt_o && mem_addr_o == v_addr_i)
        else log_mismatch("scalar not held behind a vector request");
    prio_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_req_i && v_req_i && out_cnt == 0) |-> v_gnt_o)
        else log_mismatch("vector request not granted");

    hold_store_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (vec_pending_store_i || v_out > 0) |-> !s_gnt_o)
        else log_mismatch("scalar granted during store hazard or vector response");
    hold_load_wr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (vec_pending_load_i && s_req_i && s_we_i) |-> !s_gnt_o)
        else log_mismatch("scalar write granted during pending vector load");
    load_rd_ok_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (vec_pending_load_i && !vec_pending_store_i && s_req_i && !s_we_i && !v_req_i
        && out_cnt == 0) |-> s_gnt_o)
        else log_mismatch("scalar read refused during pending vector load");

    route_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_rvalid_i && single_mode) |-> s_rvalid_o == !head_vec && v_rvalid_o == head_vec)
        else log_mismatch("response routed to the wrong port");
    err_route_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_rvalid_i && single_mode) |-> s_err_o == (!head_vec && mem_err_i)
        && v_err_o == (head_vec && mem_err_i))
        else log_mismatch("error flag routed to the wrong port");
    vid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (v_rvalid_o && single_mode) |-> v_res_id_o == head_id)
        else log_mismatch("vector response id differs from request id");
    vdata_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (v_rvalid_o && single_mode && !head_we) |-> v_rdata_o == mem_rdata_i)
        else log_mismatch("vector read data differs from the memory word");
    no_stray_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !mem_rvalid_i |-> !s_rvalid_o && !v_rvalid_o && !data_read_o
        && !s_err_o && !v_err_o)
        else log_mismatch("response pulse without memory response");
    read_flag_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> data_read_o == !head_we)
        else log_mismatch("data_read_o does not match the oldest request kind");

    backpress_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_cnt >= TRACK_DEPTH |-> !s_gnt_o && !v_gnt_o)
        else log_mismatch("grant while tracker full");

    ////////////////////
    // port drivers

    task automatic scalar_start(input logic we, input addr_t addr, input logic [3:0] be,
                                input logic [31:0] wdata);
        s_req_i   = 1'b1;
        s_we_i    = we;
        s_addr_i  = addr;
        s_be_i    = be;
        s_wdata_i = wdata;
    endtask

    task automatic scalar_finish();
        int t;
        t = 0;
        forever begin
            @(posedge clk_i);
            if (s_gnt_o) begin
                break;
            end
            t++;
            if (t > TMO) begin
                note_timeout("scalar grant");
                break;
            end
            @(negedge clk_i);
            // hazard levels fall after a few held cycles
            if (t == 4) begin
                vec_pending_load_i  = 1'b0;
                vec_pending_store_i = 1'b0;
            end
        end
        @(negedge clk_i);
        s_req_i = 1'b0;
        t = 0;
        forever begin
            @(posedge clk_i);
            if (s_rvalid_o) begin
                break;
            end
            t++;
            if (t > TMO) begin
                note_timeout("scalar response");
                break;
            end
        end
    endtask

    task automatic vector_start(input logic we, input addr_t addr, input mem_data_t wdata,
                                input vid_t id);
        v_req_i   = 1'b1;
        v_we_i    = we;
        v_addr_i  = addr;
        v_be_i    = '1;
        v_wdata_i = wdata;
        v_id_i    = id;
    endtask

    task automatic vector_finish();
        int t;
        t = 0;
        forever begin
            @(posedge clk_i);
            if (v_gnt_o) begin
                break;
            end
            t++;
            if (t > TMO) begin
                note_timeout("vector grant");
                break;
            end
        end
        @(negedge clk_i);
        v_req_i = 1'b0;
        t = 0;
        forever begin
            @(posedge clk_i);
            if (v_rvalid_o) begin
                break;
            end
            t++;
            if (t > TMO) begin
                note_timeout("vector response");
                break;
            end
        end
    endtask

    ////////////////////
    // tests

    initial begin
        addr_t       a;
        addr_t       va;
        logic [31:0] w;
        logic [31:0] r;
        mem_data_t   vw;
        vid_t        id;
        int          t;
        rst_ni              = 1'b0;
        s_req_i             = 1'b0;
        s_we_i              = 1'b0;
        s_addr_i            = '0;
        s_be_i              = '0;
        s_wdata_i           = '0;
        v_req_i             = 1'b0;
        v_we_i              = 1'b0;
        v_addr_i            = '0;
        v_be_i              = '0;
        v_wdata_i           = '0;
        v_id_i              = '0;
        vec_pending_load_i  = 1'b0;
        vec_pending_store_i = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem_arr[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
        end

        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        t = 0;
        while (!vec_rst_no && t < TMO) begin
            @(negedge clk_i);
            t++;
        end
        if (!vec_rst_no) begin
            note_timeout("vector reset release");
        end
        report_test("reset");

        // partial write, full write, then read back
        for (int i = 0; i < 6; i++) begin
            a = take_bits(5) << 2;
            r = take_bits(4);
            w = take_bits(32);
            @(negedge clk_i);
            scalar_start(1'b1, a, r[3:0], w);
            scalar_finish();
            w = take_bits(32);
            @(negedge clk_i);
            scalar_start(1'b1, a, 4'hf, w);
            scalar_finish();
            exp_sword = w;
            sread_chk = 1'b1;
            @(negedge clk_i);
            scalar_start(1'b0, a, 4'h0, 32'h0);
            scalar_finish();
            sread_chk = 1'b0;
        end
        report_test("alignment");

        for (int i = 0; i < 4; i++) begin
            a          = take_bits(5) << 2;
            va         = take_bits(4) << 3;
            r          = take_bits(5);
            vw[63:32]  = take_bits(32);
            vw[31:0]   = take_bits(32);
            id         = vid_t'(r[4:1]);
            @(negedge clk_i);
            vector_start(r[0], va, vw, id);
            scalar_start(1'b0, a, 4'h0, 32'h0);
            vector_finish();
            scalar_finish();
        end
        report_test("priority");

        // every mix of pending levels and access kind
        for (int i = 0; i < 8; i++) begin
            a = take_bits(5) << 2;
            w = take_bits(32);
            @(negedge clk_i);
            vec_pending_load_i  = i[0];
            vec_pending_store_i = i[1];
            scalar_start(i[2], a, 4'hf, w);
            scalar_finish();
        end
        @(negedge clk_i);
        vec_pending_load_i  = 1'b0;
        vec_pending_store_i = 1'b0;
        report_test("hazard hold");

        for (int i = 0; i < 16; i++) begin
            r = take_bits(2);
            if (r[0]) begin
                va        = take_bits(4) << 3;
                vw[63:32] = take_bits(32);
                vw[31:0]  = take_bits(32);
                id        = vid_t'(take_bits(4));
                @(negedge clk_i);
                vector_start(r[1], va, vw, id);
                vector_finish();
            end else begin
                a = take_bits(5) << 2;
                w = take_bits(32);
                @(negedge clk_i);
                scalar_start(r[1], a, 4'hf, w);
                scalar_finish();
            end
        end
        report_test("response split");

        // responses withheld until the tracker fills up
        @(posedge clk_i);
        hold_resp   = 1'b1;
        single_mode = 1'b0;
        @(negedge clk_i);
        va = take_bits(4) << 3;
        id = vid_t'(take_bits(4));
        vector_start(1'b0, va, vw, id);
        t = 0;
        while (out_cnt < TRACK_DEPTH && t < 2 * TRACK_DEPTH) begin
            @(negedge clk_i);
            t++;
            if (out_cnt < TRACK_DEPTH) begin
                r        = take_bits(8);
                v_we_i   = r[0];
                v_id_i   = vid_t'(r[4:1]);
                v_addr_i = addr_t'(r[7:5]) << 3;
            end
        end
        if (out_cnt < TRACK_DEPTH) begin
            note_timeout("tracker to fill");
        end
        scalar_start(1'b0, a, 4'h0, 32'h0);
        repeat (6) @(negedge clk_i);
        s_req_i = 1'b0;
        v_req_i = 1'b0;
        @(posedge clk_i);
        hold_resp = 1'b0;
        t = 0;
        while (out_cnt != 0 && t < 4 * TRACK_DEPTH) begin
            @(negedge clk_i);
            t++;
        end
        if (out_cnt != 0) begin
            note_timeout("responses to drain");
        end
        single_mode = 1'b1;
        report_test("back-pressure");

        $display("tests run: %0d, errors: %0d", tests_run, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- vec_unit_pkg.sv
// vector unit package
// constants and types seen by the vector side of the memory path

package vec_unit_pkg;

    localparam int unsigned VID_W = 4;

    // depth of the vector-side reset synchronizer
    localparam int unsigned RST_SYNC_STAGES = 4;

    typedef logic [VID_W-1:0] vid_t;

    // requester that owns the response now outstanding
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_SCALAR = 2'd1,
        SRC_VECTOR = 2'd2
    } req_src_e;

endpackage

//--- vmem_top.sv
// vector memory top
// joins the scalar and vector data ports onto one memory bus and syncs the vector reset

`timescale 1ns/1ps

module vmem_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  logic                   s_req_i,
    input  mem_bus_pkg::addr_t     s_addr_i,
    input  logic                   s_we_i,
    input  logic [3:0]             s_be_i,
    input  logic [31:0]            s_wdata_i,
    output logic                   s_gnt_o,
    output logic                   s_rvalid_o,
    output logic                   s_err_o,
    output logic [31:0]            s_rdata_o,

    input  logic                   v_req_i,
    input  mem_bus_pkg::addr_t     v_addr_i,
    input  logic                   v_we_i,
    input  mem_bus_pkg::mem_be_t   v_be_i,
    input  mem_bus_pkg::mem_data_t v_wdata_i,
    input  vec_unit_pkg::vid_t     v_id_i,
    output logic                   v_gnt_o,
    output logic                   v_rvalid_o,
    output logic                   v_err_o,
    output mem_bus_pkg::mem_data_t v_rdata_o,
    output vec_unit_pkg::vid_t     v_res_id_o,

    input  logic                   vec_pending_load_i,
    input  logic                   vec_pending_store_i,
    output logic                   vec_rst_no,

    output logic                   mem_req_o,
    output mem_bus_pkg::addr_t     mem_addr_o,
    output logic                   mem_we_o,
    output mem_bus_pkg::mem_be_t   mem_be_o,
    output mem_bus_pkg::mem_data_t mem_wdata_o,
    input  logic                   mem_rvalid_i,
    input  logic                   mem_err_i,
    input  mem_bus_pkg::mem_data_t mem_rdata_i,

    output logic                   data_read_o
);
    import mem_bus_pkg::*;

    logic trk_full;
    logic rd_done;
    logic wr_done;

    data_port_if #(.DATA_W(32))    s_port ();
    data_port_if #(.DATA_W(MEM_W)) v_port ();

    ////////////////////
    // plain ports to interfaces

    assign s_port.req   = s_req_i;
    assign s_port.addr  = s_addr_i;
    assign s_port.we    = s_we_i;
    assign s_port.be    = s_be_i;
    assign s_port.wdata = s_wdata_i;
    assign s_gnt_o      = s_port.gnt;
    assign s_rvalid_o   = s_port.rvalid;
    assign s_err_o      = s_port.err;
    assign s_rdata_o    = s_port.rdata;

    assign v_port.req   = v_req_i;
    assign v_port.addr  = v_addr_i;
    assign v_port.we    = v_we_i;
    assign v_port.be    = v_be_i;
    assign v_port.wdata = v_wdata_i;
    assign v_gnt_o      = v_port.gnt;
    assign v_rvalid_o   = v_port.rvalid;
    assign v_err_o      = v_port.err;
    assign v_rdata_o    = v_port.rdata;

    assign data_read_o  = rd_done;

    ////////////////////
    // blocks

    rst_sync u_rst_sync (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .rst_no (vec_rst_no)
    );

    data_arbiter u_data_arbiter (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .sport               (s_port),
        .vport               (v_port),
        .vreq_id_i           (v_id_i),
        .vres_id_o           (v_res_id_o),
        .vec_pending_load_i  (vec_pending_load_i),
        .vec_pending_store_i (vec_pending_store_i),
        .full_i              (trk_full),
        .rd_done_i           (rd_done),
        .wr_done_i           (wr_done),
        .mem_req_o           (mem_req_o),
        .mem_addr_o          (mem_addr_o),
        .mem_we_o            (mem_we_o),
        .mem_be_o            (mem_be_o),
        .mem_wdata_o         (mem_wdata_o),
        .mem_err_i           (mem_err_i),
        .mem_rdata_i         (mem_rdata_i)
    );

    // every bus request is accepted, so each one is tracked
    req_tracker u_req_tracker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (mem_req_o),
        .push_op_i    (mem_op_e'(mem_we_o)),
        .mem_rvalid_i (mem_rvalid_i),
        .rd_done_o    (rd_done),
        .wr_done_o    (wr_done),
        .full_o       (trk_full)
    );

endmodule
